//--- rtl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings.svh"

module aluUnit (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic clear,
	input wire logic yIn,
	input wire logic zIn,
	input wire logic hiIn,
	input wire logic loIn,
	input wire cpuPkg::aluOp opcode,
	input wire cpuPkg::cpuWord busData,
	output cpuPkg::cpuWord yValue,
	output cpuPkg::cpuWord zHighValue,
	output cpuPkg::cpuWord zLowValue,
	output cpuPkg::cpuWord hiValue,
	output cpuPkg::cpuWord loValue
);
	import cpuPkg::*;

	localparam int Width = `CPU_WORD_WIDTH;
	localparam int ShiftBits = $clog2(`CPU_WORD_WIDTH);

	logic [ShiftBits-1:0] shamt;
	logic [2*Width-1:0] rorWide;
	logic [2*Width-1:0] rolWide;
	logic signed [2*Width-1:0] product;
	cpuWord quotient;
	cpuWord remainder;
	logic [2*Width-1:0] result;

	assign shamt = busData[ShiftBits-1:0];

	// Rotates fall out of shifting a doubled copy of Y.
	assign rorWide = {yValue, yValue} >> shamt;
	assign rolWide = {yValue, yValue} << shamt;

	assign product = $signed(yValue) * $signed(busData);

	always_comb begin
		quotient = '0;
		remainder = '0;
		if (busData != '0) begin
			quotient = $signed(yValue) / $signed(busData);
			remainder = $signed(yValue) % $signed(busData);
		end
	end

	always_comb begin
		result = '0;
		case (opcode)
			opAdd: result[Width-1:0] = yValue + busData;
			opSub: result[Width-1:0] = yValue - busData;
			opAnd: result[Width-1:0] = yValue & busData;
			opOr: result[Width-1:0] = yValue | busData;
			opShr: result[Width-1:0] = yValue >> shamt;
			opShra: result[Width-1:0] = $signed(yValue) >>> shamt;
			opShl: result[Width-1:0] = yValue << shamt;
			opRor: result[Width-1:0] = rorWide[Width-1:0];
			opRol: result[Width-1:0] = rolWide[2*Width-1:Width];
			opMul: result = product;
			// Remainder high, quotient low.
			opDiv: result = {remainder, quotient};
			opNeg: result[Width-1:0] = -busData;
			opNot: result[Width-1:0] = ~busData;
			default: result = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			yValue <= '0;
			zHighValue <= '0;
			zLowValue <= '0;
			hiValue <= '0;
			loValue <= '0;
		end else if (clear) begin
			yValue <= '0;
			zHighValue <= '0;
			zLowValue <= '0;
			hiValue <= '0;
			loValue <= '0;
		end else begin
			if (yIn) begin
				yValue <= busData;
			end
			if (zIn) begin
				{zHighValue, zLowValue} <= result;
			end
			if (hiIn) begin
				hiValue <= busData;
			end
			if (loIn) begin
				loValue <= busData;
			end
		end
	end

	divideByZero: assert property (@(posedge Clock) disable iff (!rstN)
		(zIn && opcode == opDiv) |-> busData != '0)
		else $error("aluUnit: division by zero loaded into Z");

endmodule

`default_nettype wire

//--- rtl/branchCondition.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings.svh"

module branchCondition (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic clear,
	input wire logic conIn,
	input wire cpuPkg::condCode condField,
	input wire cpuPkg::cpuWord busData,
	output logic conFlag
);
	import cpuPkg::*;

	logic signBit;
	logic isZero;
	logic condMet;

	assign signBit = busData[`CPU_WORD_WIDTH-1];
	assign isZero = (busData == '0);

	always_comb begin
		condMet = 1'b0;
		case (condField)
			condZero: condMet = isZero;
			condNonzero: condMet = !isZero;
			condPositive: condMet = !signBit && !isZero;
			condNegative: condMet = signBit;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			conFlag <= 1'b0;
		end else if (clear) begin
			conFlag <= 1'b0;
		end else if (conIn) begin
			conFlag <= condMet;
		end
	end

endmodule

`default_nettype wire

//--- rtl/busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux (
	input wire logic hiOut,
	input wire logic loOut,
	input wire logic yOut,
	input wire logic zHighOut,
	input wire logic zLowOut,
	input wire logic pcOut,
	input wire logic mdrOut,
	input wire logic inPortOut,
	input wire logic cOut,
	input wire logic rOut,
	input wire logic baOut,
	input wire cpuPkg::cpuWord regOutValue,
	input wire cpuPkg::cpuWord pcValue,
	input wire cpuPkg::cpuWord constValue,
	input wire cpuPkg::cpuWord yValue,
	input wire cpuPkg::cpuWord zHighValue,
	input wire cpuPkg::cpuWord zLowValue,
	input wire cpuPkg::cpuWord hiValue,
	input wire cpuPkg::cpuWord loValue,
	input wire cpuPkg::cpuWord mdrValue,
	input wire cpuPkg::cpuWord inPortValue,
	output cpuPkg::cpuWord busData
);

	logic [3:0] srcSel;

	// Source index, zero when nothing drives the bus.
	always_comb begin
		srcSel = 4'd0;
		if (rOut || baOut) begin
			srcSel = 4'd1;
		end else if (pcOut) begin
			srcSel = 4'd2;
		end else if (cOut) begin
			srcSel = 4'd3;
		end else if (yOut) begin
			srcSel = 4'd4;
		end else if (zHighOut) begin
			srcSel = 4'd5;
		end else if (zLowOut) begin
			srcSel = 4'd6;
		end else if (hiOut) begin
			srcSel = 4'd7;
		end else if (loOut) begin
			srcSel = 4'd8;
		end else if (mdrOut) begin
			srcSel = 4'd9;
		end else if (inPortOut) begin
			srcSel = 4'd10;
		end
	end

	always_comb begin
		case (srcSel)
			4'd1: busData = regOutValue;
			4'd2: busData = pcValue;
			4'd3: busData = constValue;
			4'd4: busData = yValue;
			4'd5: busData = zHighValue;
			4'd6: busData = zLowValue;
			4'd7: busData = hiValue;
			4'd8: busData = loValue;
			4'd9: busData = mdrValue;
			4'd10: busData = inPortValue;
			default: busData = '0;
		endcase
	end

	always_comb begin
		strobeOneHot: assert final ($onehot0({hiOut, loOut, yOut, zHighOut, zLowOut, pcOut,
			mdrOut, inPortOut, cOut, rOut, baOut}))
			else $error("busMux: more than one block drives the bus");
	end

endmodule

`default_nettype wire

//--- rtl/cpuPkg.sv
`default_nettype none
`include "cpuSettings.svh"

package cpuPkg;

	typedef logic [`CPU_WORD_WIDTH-1:0] cpuWord;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIndex;
	typedef logic [$clog2(`CPU_RAM_DEPTH)-1:0] memAddr;
	typedef logic [1:0] condCode;

	// Branch conditions held in C2.
	localparam condCode condZero = 2'd0;
	localparam condCode condNonzero = 2'd1;
	localparam condCode condPositive = 2'd2;
	localparam condCode condNegative = 2'd3;

	typedef enum logic [4:0] {
		opAdd = 5'b00011,
		opSub = 5'b00100,
		opAnd = 5'b00101,
		opOr = 5'b00110,
		opShr = 5'b00111,
		opShra = 5'b01000,
		opShl = 5'b01001,
		opRor = 5'b01010,
		opRol = 5'b01011,
		opMul = 5'b01111,
		opDiv = 5'b10000,
		opNeg = 5'b10001,
		opNot = 5'b10010
	} aluOp;

endpackage

`default_nettype wire

//--- rtl/cpuSettings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath dimensions.
`define CPU_WORD_WIDTH 32
`define CPU_REG_COUNT 16
`define CPU_RAM_DEPTH 512

// Register fields of IR. The rb field doubles as C2.
`define CPU_RA_MSB 26
`define CPU_RA_LSB 23
`define CPU_RB_MSB 22
`define CPU_RB_LSB 19
`define CPU_RC_MSB 18
`define CPU_RC_LSB 15

// Constant field runs from this bit down to bit 0.
`define CPU_CONST_MSB 18

`endif

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic clear,
	input wire logic read,
	input wire logic write,
	input wire logic incPc,
	input wire cpuPkg::aluOp opcode,
	input wire logic gra, grb, grc,
	input wire logic rIn, rOut, baOut,
	input wire logic hiIn, loIn, yIn, zIn,
	input wire logic pcIn, irIn, marIn, mdrIn,
	input wire logic outPortIn, conIn,
	input wire logic hiOut, loOut, yOut, zHighOut, zLowOut,
	input wire logic pcOut, mdrOut, inPortOut, cOut,
	input wire cpuPkg::cpuWord inPortData,
	output cpuPkg::cpuWord outPortData,
	output logic conFlag,
	output cpuPkg::cpuWord busData
);
	import cpuPkg::*;

	cpuWord regOutValue;
	cpuWord pcValue;
	cpuWord constValue;
	cpuWord yValue;
	cpuWord zHighValue;
	cpuWord zLowValue;
	cpuWord hiValue;
	cpuWord loValue;
	cpuWord mdrValue;
	cpuWord inPortValue;
	regIndex raField;
	regIndex rbField;
	regIndex rcField;
	condCode condField;

	registerFile regs (.Clock, .rstN, .clear, .gra, .grb, .grc, .rIn, .rOut, .baOut,
		.raField, .rbField, .rcField, .busData, .regOutValue);

	instructionUnit instr (.Clock, .rstN, .clear, .pcIn, .irIn, .incPc, .busData,
		.pcValue, .constValue, .raField, .rbField, .rcField, .condField);

	aluUnit alu (.Clock, .rstN, .clear, .yIn, .zIn, .hiIn, .loIn, .opcode, .busData,
		.yValue, .zHighValue, .zLowValue, .hiValue, .loValue);

	branchCondition branch (.Clock, .rstN, .clear, .conIn, .condField, .busData, .conFlag);

	memoryIoUnit memIo (.Clock, .rstN, .clear, .marIn, .mdrIn, .read, .write, .outPortIn,
		.busData, .inPortData, .mdrValue, .inPortValue, .outPortData);

	// Sole driver of the shared bus.
	busMux bus (.hiOut, .loOut, .yOut, .zHighOut, .zLowOut, .pcOut, .mdrOut, .inPortOut,
		.cOut, .rOut, .baOut, .regOutValue, .pcValue, .constValue, .yValue, .zHighValue,
		.zLowValue, .hiValue, .loValue, .mdrValue, .inPortValue, .busData);

endmodule

`default_nettype wire

//--- rtl/instructionUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings.svh"

module instructionUnit (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic clear,
	input wire logic pcIn,
	input wire logic irIn,
	input wire logic incPc,
	input wire cpuPkg::cpuWord busData,
	output cpuPkg::cpuWord pcValue,
	output cpuPkg::cpuWord constValue,
	output cpuPkg::regIndex raField,
	output cpuPkg::regIndex rbField,
	output cpuPkg::regIndex rcField,
	output cpuPkg::condCode condField
);
	import cpuPkg::*;

	cpuWord ir;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pcValue <= '0;
			ir <= '0;
		end else if (clear) begin
			pcValue <= '0;
			ir <= '0;
		end else begin
			if (pcIn) begin
				pcValue <= incPc ? pcValue + 1'b1 : busData;
			end
			if (irIn) begin
				ir <= busData;
			end
		end
	end

	assign raField = ir[`CPU_RA_MSB:`CPU_RA_LSB];
	assign rbField = ir[`CPU_RB_MSB:`CPU_RB_LSB];
	assign rcField = ir[`CPU_RC_MSB:`CPU_RC_LSB];
	// C2 sits in the low two bits of the rb field.
	assign condField = ir[`CPU_RB_LSB+1:`CPU_RB_LSB];

	assign constValue = {{(`CPU_WORD_WIDTH - `CPU_CONST_MSB - 1){ir[`CPU_CONST_MSB]}},
		ir[`CPU_CONST_MSB:0]};

endmodule

`default_nettype wire

//--- rtl/memoryIoUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings.svh"

module memoryIoUnit (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic clear,
	input wire logic marIn,
	input wire logic mdrIn,
	input wire logic read,
	input wire logic write,
	input wire logic outPortIn,
	input wire cpuPkg::cpuWord busData,
	input wire cpuPkg::cpuWord inPortData,
	output cpuPkg::cpuWord mdrValue,
	output cpuPkg::cpuWord inPortValue,
	output cpuPkg::cpuWord outPortData
);
	import cpuPkg::*;

	cpuWord mar;
	cpuWord ram [`CPU_RAM_DEPTH];
	memAddr ramAddr;

	// Only the low bits of MAR reach the RAM.
	assign ramAddr = memAddr'(mar);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			mar <= '0;
			mdrValue <= '0;
			inPortValue <= '0;
			outPortData <= '0;
		end else if (clear) begin
			mar <= '0;
			mdrValue <= '0;
			inPortValue <= '0;
			outPortData <= '0;
		end else begin
			if (marIn) begin
				mar <= busData;
			end
			if (mdrIn) begin
				mdrValue <= read ? ram[ramAddr] : busData;
			end
			inPortValue <= inPortData;
			if (outPortIn) begin
				outPortData <= busData;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (write) begin
			ram[ramAddr] <= mdrValue;
		end
	end

	readWriteExclusive: assert property (@(posedge Clock) disable iff (!rstN)
		!(read && write))
		else $error("memoryIoUnit: read and write high in the same cycle");

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings.svh"

module registerFile (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic clear,
	input wire logic gra,
	input wire logic grb,
	input wire logic grc,
	input wire logic rIn,
	input wire logic rOut,
	input wire logic baOut,
	input wire cpuPkg::regIndex raField,
	input wire cpuPkg::regIndex rbField,
	input wire cpuPkg::regIndex rcField,
	input wire cpuPkg::cpuWord busData,
	output cpuPkg::cpuWord regOutValue
);
	import cpuPkg::*;

	cpuWord regs [`CPU_REG_COUNT];
	regIndex selIndex;
	cpuWord selValue;

	// Register number comes from the IR field picked by the select strobes.
	always_comb begin
		selIndex = '0;
		if (gra) begin
			selIndex = raField;
		end else if (grb) begin
			selIndex = rbField;
		end else if (grc) begin
			selIndex = rcField;
		end
	end

	assign selValue = regs[selIndex];

	// Base address reads give zero for R0.
	always_comb begin
		regOutValue = '0;
		if (rOut) begin
			regOutValue = selValue;
		end else if (baOut && selIndex != '0) begin
			regOutValue = selValue;
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (clear) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[selIndex] <= busData;
		end
	end

	selectOneHot: assert property (@(posedge Clock) disable iff (!rstN)
		$onehot0({gra, grb, grc}))
		else $error("registerFile: more than one of gra, grb, grc is high");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
verilator --binary --assert -f sim.f --top-module datapathTb -o datapathSim \
	&& ./obj_dir/datapathSim > sim.log 2>&1 \
	; cat sim.log \
	&& grep -q "^STATUS: PASS$" sim.log \
	|| { echo "Simulation did not pass"; exit 1; }

//--- sim.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/instructionUnit.sv
rtl/aluUnit.sv
rtl/branchCondition.sv
rtl/memoryIoUnit.sv
rtl/busMux.sv
rtl/datapath.sv
sim/datapathTb.sv

//--- sim/datapathStimulus.txt
# Columns: control word, ALU opcode, inPortData, check flag, expected outPortData, expected conFlag.
# All hex. Control bit order is listed in datapathTb.sv. A line starting with T names a test.
T reset
00000000 03 00800000 1 00000000 0
T ioPort
08008000 03 12345678 0 00000000 0
08000090 03 12345678 0 00000000 0
00040110 03 800000F0 1 12345678 0
T aluOps
08001000 03 00000010 0 00000000 0
08002000 03 00000010 0 00000000 0
01040000 03 000000F1 1 80000100 0
08002000 04 000000F1 0 00000000 0
01040000 04 000000A5 1 7FFFFFFF 0
08002000 05 000000A5 0 00000000 0
01040000 05 0F0F000F 1 000000A0 0
08002000 06 0F0F000F 0 00000000 0
01040000 06 00000004 1 8F0F00FF 0
08002000 07 00000004 0 00000000 0
01040000 07 00000004 1 0800000F 0
08002000 08 00000004 0 00000000 0
01040000 08 00000004 1 F800000F 0
08002000 09 00000004 0 00000000 0
01040000 09 00000008 1 00000F00 0
08002000 0A 00000008 0 00000000 0
01040000 0A 00000004 1 F0800000 0
08002000 0B 00000004 0 00000000 0
01040000 0B 00000005 1 00000F08 0
08002000 11 00000005 0 00000000 0
01040000 11 0F0FF0F0 1 FFFFFFFB 0
08002000 12 0F0FF0F0 0 00000000 0
01040000 12 00012345 1 F0F00F0F 0
T mulDiv
08001000 0F 00100000 0 00000000 0
08002000 0F 00100000 0 00000000 0
00800400 0F 00100000 0 00000000 0
01000800 0F 00100000 0 00000000 0
00140000 0F 00100000 1 00000012 0
00240000 0F FFFFFFE9 1 34500000 0
08001000 10 00000005 0 00000000 0
08002000 10 00000005 0 00000000 0
00800400 10 00000005 0 00000000 0
01000800 10 00000005 0 00000000 0
00140000 10 00000005 1 FFFFFFFD 0
00240000 10 00000025 1 FFFFFFFC 0
T memFetch
08010000 03 CAFEF00D 0 00000000 0
08020000 03 00000000 0 00000000 0
08020004 03 00000000 0 00000000 0
00020002 03 00000000 0 00000000 0
04040000 03 00000041 1 CAFEF00D 0
08004000 03 00000041 0 00000000 0
0400C008 03 00000041 0 00000000 0
02040000 03 00000041 1 00000042 0
10040000 03 01000000 1 FFFEF00D 0
T condClear
08008000 03 FFFF0000 0 00000000 0
08000090 03 00000000 0 00000000 0
08008000 03 00088000 0 00000000 0
00080140 03 00088000 1 FFFEF00D 1
08008000 03 00110000 0 00000000 0
00080140 03 00110000 1 FFFEF00D 1
08008000 03 00190000 0 00000000 0
00080140 03 00190000 1 FFFEF00D 0
08008000 03 00108000 0 00000000 0
00080140 03 00108000 1 FFFEF00D 1
08008000 03 00108000 0 00000000 0
00080140 03 00108000 1 FFFEF00D 1
00000001 03 00000000 1 00000000 0

//--- sim/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTb;
	import cpuPkg::*;

	localparam int ClockHalf = 4;
	localparam int ResetCycles = 4;
	localparam int ResetTimeout = 20;
	localparam int LineLimit = 1000;

	logic Clock;
	logic rstN;
	// Control word bits 0..28 in order:
	// clear read write incPc gra grb grc rIn rOut baOut hiIn loIn yIn zIn pcIn irIn
	// marIn mdrIn outPortIn conIn hiOut loOut yOut zHighOut zLowOut pcOut mdrOut
	// inPortOut cOut.
	logic [28:0] ctrl;
	aluOp opcode;
	cpuWord inPortData;
	cpuWord outPortData;
	logic conFlag;
	cpuWord busData;

	int fd;
	int lineCount;
	int testCount;
	int checkCount;
	int errorCount;
	int testChecks;
	int testErrors;
	logic testActive;
	logic aborted;
	string testName;

	datapath dut (
		.Clock,
		.rstN,
		.clear(ctrl[0]),
		.read(ctrl[1]),
		.write(ctrl[2]),
		.incPc(ctrl[3]),
		.opcode,
		.gra(ctrl[4]),
		.grb(ctrl[5]),
		.grc(ctrl[6]),
		.rIn(ctrl[7]),
		.rOut(ctrl[8]),
		.baOut(ctrl[9]),
		.hiIn(ctrl[10]),
		.loIn(ctrl[11]),
		.yIn(ctrl[12]),
		.zIn(ctrl[13]),
		.pcIn(ctrl[14]),
		.irIn(ctrl[15]),
		.marIn(ctrl[16]),
		.mdrIn(ctrl[17]),
		.outPortIn(ctrl[18]),
		.conIn(ctrl[19]),
		.hiOut(ctrl[20]),
		.loOut(ctrl[21]),
		.yOut(ctrl[22]),
		.zHighOut(ctrl[23]),
		.zLowOut(ctrl[24]),
		.pcOut(ctrl[25]),
		.mdrOut(ctrl[26]),
		.inPortOut(ctrl[27]),
		.cOut(ctrl[28]),
		.inPortData,
		.outPortData,
		.conFlag,
		.busData
	);

	initial begin
		Clock = 1'b0;
		forever #ClockHalf Clock = ~Clock;
	end

	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		rstN = 1'b1;
	end

	// Drops line endings and trailing blanks.
	function automatic string trimEnd(string text);
		int last;
		last = text.len() - 1;
		while (last >= 0 && (text.getc(last) == 8'h0a || text.getc(last) == 8'h0d
			|| text.getc(last) == 8'h20)) begin
			last--;
		end
		if (last < 0) begin
			return "";
		end
		return text.substr(0, last);
	endfunction

	task automatic waitForReset();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < ResetTimeout) begin
			@(posedge Clock);
			cycles++;
		end
		if (rstN !== 1'b1) begin
			$display("Reset was not released within %0d cycles", ResetTimeout);
			aborted = 1'b1;
		end
		@(negedge Clock);
	endtask

	task automatic closeTest();
		if (testActive) begin
			$display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
			testCount++;
		end
		testChecks = 0;
		testErrors = 0;
	endtask

	// One control step, driven on the falling edge and checked after the rising edge.
	task automatic applyStep(input logic [31:0] ctrlWord, input logic [31:0] opWord,
		input cpuWord inWord, input logic [31:0] checkWord, input cpuWord expOut,
		input logic [31:0] expCon);
		ctrl = ctrlWord[28:0];
		opcode = aluOp'(opWord[4:0]);
		inPortData = inWord;
		@(posedge Clock);
		#1;
		// With no out-strobe the bus reads zero.
		if (ctrlWord[28:20] == '0 && ctrlWord[9:8] == '0) begin
			checkCount++;
			testChecks++;
			assert (busData == '0) else begin
				$display("[ERROR] %s: busData expected %h, actual %h", testName, 32'h0,
					busData);
				errorCount++;
				testErrors++;
			end
		end
		if (checkWord != 0) begin
			checkCount++;
			testChecks++;
			assert (outPortData == expOut) else begin
				$display("[ERROR] %s: outPortData expected %h, actual %h", testName, expOut,
					outPortData);
				errorCount++;
				testErrors++;
			end
			assert (conFlag == expCon[0]) else begin
				$display("[ERROR] %s: conFlag expected %0d, actual %0d", testName, expCon[0],
					conFlag);
				errorCount++;
				testErrors++;
			end
		end
		@(negedge Clock);
	endtask

	task automatic runStimulus();
		string line;
		logic [31:0] ctrlWord;
		logic [31:0] opWord;
		logic [31:0] inWord;
		logic [31:0] checkWord;
		logic [31:0] expOut;
		logic [31:0] expCon;
		int fields;
		fd = $fopen("sim/datapathStimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			aborted = 1'b1;
			return;
		end
		while (!$feof(fd) && lineCount < LineLimit) begin
			line = "";
			void'($fgets(line, fd));
			lineCount++;
			line = trimEnd(line);
			if (line.len() == 0 || line.getc(0) == "#") begin
				continue;
			end
			if (line.getc(0) == "T") begin
				closeTest();
				testName = line.substr(2, line.len() - 1);
				testActive = 1'b1;
				continue;
			end
			fields = $sscanf(line, "%h %h %h %h %h %h", ctrlWord, opWord, inWord, checkWord,
				expOut, expCon);
			if (fields != 6) begin
				$display("Stimulus line %0d could not be parsed", lineCount);
				errorCount++;
				continue;
			end
			applyStep(ctrlWord, opWord, inWord, checkWord, expOut, expCon);
		end
		if (!$feof(fd)) begin
			$display("Stimulus file did not end within %0d lines", LineLimit);
			aborted = 1'b1;
		end
		closeTest();
		testActive = 1'b0;
		$fclose(fd);
	endtask

	initial begin
		ctrl = '0;
		opcode = opAdd;
		inPortData = '0;
		lineCount = 0;
		testCount = 0;
		checkCount = 0;
		errorCount = 0;
		testChecks = 0;
		testErrors = 0;
		testActive = 1'b0;
		aborted = 1'b0;
		testName = "";
		waitForReset();
		if (!aborted) begin
			runStimulus();
		end
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0 && !aborted && checkCount > 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
